// ==== source/htu_config.svh ====
`ifndef HTU_CONFIG_SVH
`define HTU_CONFIG_SVH

// address layout, bits 31:4 arrive from the crossbar
`define HTU_ADDR_W   32
`define HTU_TAG_W    22
`define HTU_BANK_W   2
`define HTU_INDEX_W  3

// tag store geometry
`define HTU_WAY_W    3
`define HTU_SETS     8
`define HTU_WAYS     8

// request side
`define HTU_CH_W     2

// issue word is {index, way, offset}
`define HTU_ISSUE_W  7

`endif

// ==== source/htu_pkg.sv ====
`default_nettype none

`include "htu_config.svh"

package htu_pkg;

  // field view of address bits 31:4
  typedef struct packed {
    logic [`HTU_TAG_W-1:0]   tag;
    logic [`HTU_BANK_W-1:0]  bank;
    logic [`HTU_INDEX_W-1:0] index;
    logic                    offset;
  } htu_addr_fields_t;

  // line view, line address goes to the bus interface
  typedef struct packed {
    logic [`HTU_ADDR_W-6:0] line;
    logic                   offset;
  } htu_addr_line_t;

  typedef union packed {
    htu_addr_fields_t f;
    htu_addr_line_t   l;
  } htu_addr_t;

  // per half-line state
  typedef enum logic [1:0] {
    EMPTY = 2'b00,
    CLEAN = 2'b01,
    DIRTY = 2'b10
  } line_state_t;

  typedef logic [`HTU_WAYS-1:0][`HTU_TAG_W-1:0] way_tags_t;
  typedef logic [`HTU_WAYS-1:0]                 way_vec_t;

endpackage

`default_nettype wire

// ==== source/htu_tag_array.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "htu_config.svh"

module htu_tag_array
  import htu_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  // lookup
  input  wire [`HTU_INDEX_W-1:0]  index_i,
  input  wire [`HTU_TAG_W-1:0]    tag_i,
  input  wire                     offset_i,
  // update from dispatch
  input  wire                     upd_en_i,
  input  wire [`HTU_WAY_W-1:0]    upd_way_i,
  input  wire                     upd_alloc_i,
  input  wire line_state_t        upd_state_i,
  // lookup results
  output logic                    hit_o,
  output logic [`HTU_WAY_W-1:0]   hit_way_o,
  output line_state_t             state0_o,
  output line_state_t             state1_o,
  output way_tags_t               set_tags_o,
  output way_vec_t                set_valid_o,
  output way_vec_t                set_dirty_o
);

  localparam int WAY_W = `HTU_WAY_W;

  logic [`HTU_TAG_W-1:0] tag_q [`HTU_SETS][`HTU_WAYS];
  way_vec_t              valid_q [`HTU_SETS];
  line_state_t           st0_q [`HTU_SETS][`HTU_WAYS];
  line_state_t           st1_q [`HTU_SETS][`HTU_WAYS];

  way_vec_t              hit_vec;

  // ------------------------------------------------------------
  // lookup of the indexed set
  // ------------------------------------------------------------
  always_comb begin
    hit_vec   = '0;
    hit_way_o = '0;
    for (int w = 0; w < `HTU_WAYS; w++) begin
      hit_vec[w]     = valid_q[index_i][w] && (tag_q[index_i][w] == tag_i);
      set_tags_o[w]  = tag_q[index_i][w];
      // a way counts as dirty if either half is
      set_dirty_o[w] = (st0_q[index_i][w] == DIRTY) || (st1_q[index_i][w] == DIRTY);
      if (hit_vec[w]) begin
        hit_way_o = WAY_W'(w);
      end
    end
  end

  assign hit_o       = |hit_vec;
  assign set_valid_o = valid_q[index_i];

  // half states of the hit line, empty on a miss
  assign state0_o = hit_o ? st0_q[index_i][hit_way_o] : EMPTY;
  assign state1_o = hit_o ? st1_q[index_i][hit_way_o] : EMPTY;

  // ------------------------------------------------------------
  // state update on accept
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `HTU_SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < `HTU_WAYS; w++) begin
          st0_q[s][w] <= EMPTY;
          st1_q[s][w] <= EMPTY;
        end
      end
    end else if (upd_en_i) begin
      if (upd_alloc_i) begin
        valid_q[index_i][upd_way_i] <= 1'b1;
        st0_q[index_i][upd_way_i]   <= EMPTY;
        st1_q[index_i][upd_way_i]   <= EMPTY;
      end
      // addressed half last, overrides the clear above
      if (offset_i) begin
        st1_q[index_i][upd_way_i] <= upd_state_i;
      end else begin
        st0_q[index_i][upd_way_i] <= upd_state_i;
      end
    end
  end

  // tag payload
  always_ff @(posedge clk_i) begin
    if (upd_en_i && upd_alloc_i) begin
      tag_q[index_i][upd_way_i] <= tag_i;
    end
  end

  // allocation only on miss keeps tags within a set unique
  a_single_hit : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(hit_vec)
  );

endmodule

`default_nettype wire

// ==== source/htu_victim_select.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "htu_config.svh"

module htu_victim_select (
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire [`HTU_INDEX_W-1:0]  index_i,
  input  wire                     alloc_en_i,
  output logic [`HTU_WAY_W-1:0]   victim_way_o
);

  // ------------------------------------------------------------
  // round-robin pointer per set
  // ------------------------------------------------------------
  logic [`HTU_WAY_W-1:0] ptr_q [`HTU_SETS];
  logic [`HTU_WAY_W-1:0] ptr_nxt;

  assign victim_way_o = ptr_q[index_i];

  // 3-bit add wraps 7 back to 0
  assign ptr_nxt = victim_way_o + 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `HTU_SETS; s++) begin
        ptr_q[s] <= '0;
      end
    end else if (alloc_en_i) begin
      ptr_q[index_i] <= ptr_nxt;
    end
  end

  // dispatch must keep quiet while the bank is held in reset
  a_no_alloc_in_reset : assert property (
    @(posedge clk_i)
    !rst_n_i |-> !alloc_en_i
  );

endmodule

`default_nettype wire

// ==== source/htu_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "htu_config.svh"

module htu_dispatch
  import htu_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  // crossbar request
  input  wire                      req_valid_i,
  input  wire                      req_write_i,
  input  wire [`HTU_CH_W-1:0]      req_ch_id_i,
  input  wire [`HTU_ADDR_W-6:0]    req_line_i,
  input  wire [`HTU_INDEX_W-1:0]   index_i,
  input  wire                      offset_i,
  input  wire [`HTU_BANK_W-1:0]    bank_i,
  output logic                     req_allow_o,
  // ready inputs
  input  wire                      isu_allow_i,
  input  wire                      biu_arready_i,
  input  wire                      biu_awready_i,
  // tag array and victim results
  input  wire                      hit_i,
  input  wire [`HTU_WAY_W-1:0]     hit_way_i,
  input  wire line_state_t         state0_i,
  input  wire line_state_t         state1_i,
  input  wire way_tags_t           set_tags_i,
  input  wire way_vec_t            set_valid_i,
  input  wire way_vec_t            set_dirty_i,
  input  wire [`HTU_WAY_W-1:0]     victim_way_i,
  // issue unit
  output logic                     isu_valid_o,
  output logic                     isu_write_o,
  output logic                     isu_evict_o,
  output logic [`HTU_CH_W-1:0]     isu_ch_id_o,
  output logic [`HTU_ISSUE_W-1:0]  isu_set_way_offset_o,
  output logic                     isu_linefill_o,
  output line_state_t              isu_state0_o,
  output line_state_t              isu_state1_o,
  // bus interface
  output logic                     biu_arvalid_o,
  output logic [`HTU_ADDR_W-6:0]   biu_araddr_o,
  output logic                     biu_awvalid_o,
  output logic [`HTU_ADDR_W-6:0]   biu_awaddr_o,
  // state update
  output logic                     upd_en_o,
  output logic [`HTU_WAY_W-1:0]    upd_way_o,
  output logic                     upd_alloc_o,
  output line_state_t              upd_state_o,
  output logic                     alloc_en_o
);

  line_state_t             access_state;
  logic [`HTU_WAY_W-1:0]   access_way;
  logic                    need_linefill;
  logic                    need_evict;
  logic                    ar_ok;
  logic                    aw_ok;
  logic                    accept;
  htu_addr_t               wb_addr;

  // ------------------------------------------------------------
  // decisions
  // ------------------------------------------------------------
  assign access_state  = offset_i ? state1_i : state0_i;
  assign access_way    = hit_i ? hit_way_i : victim_way_i;

  // read miss, or read hit on an empty half
  assign need_linefill = !req_write_i && (!hit_i || access_state == EMPTY);
  assign need_evict    = !hit_i && set_valid_i[victim_way_i] && set_dirty_i[victim_way_i];

  assign ar_ok = !need_linefill || biu_arready_i;
  assign aw_ok = !need_evict || biu_awready_i;

  assign req_allow_o = isu_allow_i && ar_ok && aw_ok;
  assign accept      = req_valid_i && req_allow_o;

  // ------------------------------------------------------------
  // issue unit
  // ------------------------------------------------------------
  assign isu_valid_o          = req_valid_i && ar_ok && aw_ok;
  assign isu_write_o          = req_write_i;
  assign isu_evict_o          = need_evict;
  assign isu_ch_id_o          = req_ch_id_i;
  assign isu_set_way_offset_o = {index_i, access_way, offset_i};
  assign isu_linefill_o       = need_linefill;
  assign isu_state0_o         = state0_i;
  assign isu_state1_o         = state1_i;

  // ------------------------------------------------------------
  // bus interface
  // ------------------------------------------------------------
  // victim line address rebuilt from its stored tag
  always_comb begin
    wb_addr         = '0;
    wb_addr.f.tag   = set_tags_i[victim_way_i];
    wb_addr.f.bank  = bank_i;
    wb_addr.f.index = index_i;
  end

  assign biu_arvalid_o = req_valid_i && need_linefill && isu_allow_i;
  assign biu_araddr_o  = req_line_i;
  assign biu_awvalid_o = req_valid_i && need_evict && isu_allow_i;
  assign biu_awaddr_o  = wb_addr.l.line;

  // ------------------------------------------------------------
  // store and pointer update
  // ------------------------------------------------------------
  assign upd_en_o    = accept;
  assign upd_way_o   = access_way;
  assign upd_alloc_o = !hit_i;
  assign alloc_en_o  = accept && !hit_i;

  always_comb begin
    if (req_write_i) begin
      upd_state_o = DIRTY;
    end else if (access_state == EMPTY) begin
      upd_state_o = CLEAN;
    end else begin
      upd_state_o = access_state;
    end
  end

  // a bus request held off by its ready keeps the crossbar request offered
  a_ar_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    biu_arvalid_o && !biu_arready_i |=> req_valid_i
  );

  a_aw_needs_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    biu_awvalid_o && !biu_awready_i |=> req_valid_i
  );

endmodule

`default_nettype wire

// ==== source/bank_htu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "htu_config.svh"

module bank_htu_top
  import htu_pkg::*;
(
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  // crossbar >> htu
  input  wire                      req_valid_i,
  input  wire                      req_write_i,
  input  wire [`HTU_CH_W-1:0]      req_ch_id_i,
  input  wire htu_addr_t           req_addr_i,
  output logic                     req_allow_o,
  // htu >> issue unit
  output logic                     isu_valid_o,
  input  wire                      isu_allow_i,
  output logic                     isu_write_o,
  output logic                     isu_evict_o,
  output logic [`HTU_CH_W-1:0]     isu_ch_id_o,
  output logic [`HTU_ISSUE_W-1:0]  isu_set_way_offset_o,
  output logic                     isu_linefill_o,
  output line_state_t              isu_state0_o,
  output line_state_t              isu_state1_o,
  // htu >> bus interface
  output logic                     biu_arvalid_o,
  input  wire                      biu_arready_i,
  output logic [`HTU_ADDR_W-6:0]   biu_araddr_o,
  output logic                     biu_awvalid_o,
  input  wire                      biu_awready_i,
  output logic [`HTU_ADDR_W-6:0]   biu_awaddr_o
);

  // ------------------------------------------------------------
  // address fields
  // ------------------------------------------------------------
  logic [`HTU_TAG_W-1:0]    req_tag;
  logic [`HTU_BANK_W-1:0]   req_bank;
  logic [`HTU_INDEX_W-1:0]  req_index;
  logic                     req_offset;
  logic [`HTU_ADDR_W-6:0]   req_line;

  assign req_tag    = req_addr_i.f.tag;
  assign req_bank   = req_addr_i.f.bank;
  assign req_index  = req_addr_i.f.index;
  assign req_offset = req_addr_i.f.offset;
  assign req_line   = req_addr_i.l.line;

  logic                     hit;
  logic [`HTU_WAY_W-1:0]    hit_way;
  line_state_t              hit_state0;
  line_state_t              hit_state1;
  way_tags_t                set_tags;
  way_vec_t                 set_valid;
  way_vec_t                 set_dirty;
  logic [`HTU_WAY_W-1:0]    victim_way;
  logic                     upd_en;
  logic [`HTU_WAY_W-1:0]    upd_way;
  logic                     upd_alloc;
  line_state_t              upd_state;
  logic                     alloc_en;

  htu_tag_array u_tag_array (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .index_i     (req_index),
    .tag_i       (req_tag),
    .offset_i    (req_offset),
    .upd_en_i    (upd_en),
    .upd_way_i   (upd_way),
    .upd_alloc_i (upd_alloc),
    .upd_state_i (upd_state),
    .hit_o       (hit),
    .hit_way_o   (hit_way),
    .state0_o    (hit_state0),
    .state1_o    (hit_state1),
    .set_tags_o  (set_tags),
    .set_valid_o (set_valid),
    .set_dirty_o (set_dirty)
  );

  htu_victim_select u_victim_select (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .index_i      (req_index),
    .alloc_en_i   (alloc_en),
    .victim_way_o (victim_way)
  );

  htu_dispatch u_dispatch (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .req_valid_i          (req_valid_i),
    .req_write_i          (req_write_i),
    .req_ch_id_i          (req_ch_id_i),
    .req_line_i           (req_line),
    .index_i              (req_index),
    .offset_i             (req_offset),
    .bank_i               (req_bank),
    .req_allow_o          (req_allow_o),
    .isu_allow_i          (isu_allow_i),
    .biu_arready_i        (biu_arready_i),
    .biu_awready_i        (biu_awready_i),
    .hit_i                (hit),
    .hit_way_i            (hit_way),
    .state0_i             (hit_state0),
    .state1_i             (hit_state1),
    .set_tags_i           (set_tags),
    .set_valid_i          (set_valid),
    .set_dirty_i          (set_dirty),
    .victim_way_i         (victim_way),
    .isu_valid_o          (isu_valid_o),
    .isu_write_o          (isu_write_o),
    .isu_evict_o          (isu_evict_o),
    .isu_ch_id_o          (isu_ch_id_o),
    .isu_set_way_offset_o (isu_set_way_offset_o),
    .isu_linefill_o       (isu_linefill_o),
    .isu_state0_o         (isu_state0_o),
    .isu_state1_o         (isu_state1_o),
    .biu_arvalid_o        (biu_arvalid_o),
    .biu_araddr_o         (biu_araddr_o),
    .biu_awvalid_o        (biu_awvalid_o),
    .biu_awaddr_o         (biu_awaddr_o),
    .upd_en_o             (upd_en),
    .upd_way_o            (upd_way),
    .upd_alloc_o          (upd_alloc),
    .upd_state_o          (upd_state),
    .alloc_en_o           (alloc_en)
  );

endmodule

`default_nettype wire

// ==== sim/tb_bank_htu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "htu_config.svh"

module tb_bank_htu_top
  import htu_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int N_DIRECTED   = 23;
  localparam int N_RANDOM     = 200;
  localparam int N_TRANS      = N_DIRECTED + N_RANDOM;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + N_TRANS * 20) * CLK_PERIOD;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     req_valid_i;
  logic                     req_write_i;
  logic [`HTU_CH_W-1:0]     req_ch_id_i;
  htu_addr_t                req_addr_i;
  logic                     req_allow_o;
  logic                     isu_valid_o;
  logic                     isu_allow_i;
  logic                     isu_write_o;
  logic                     isu_evict_o;
  logic [`HTU_CH_W-1:0]     isu_ch_id_o;
  logic [`HTU_ISSUE_W-1:0]  isu_set_way_offset_o;
  logic                     isu_linefill_o;
  line_state_t              isu_state0_o;
  line_state_t              isu_state1_o;
  logic                     biu_arvalid_o;
  logic                     biu_arready_i;
  logic [`HTU_ADDR_W-6:0]   biu_araddr_o;
  logic                     biu_awvalid_o;
  logic                     biu_awready_i;
  logic [`HTU_ADDR_W-6:0]   biu_awaddr_o;

  int          errors;
  int          n_trans;
  string       test_name;
  logic [31:0] lcg_state;

  bank_htu_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // reference tag store
  // ------------------------------------------------------------
  logic [`HTU_TAG_W-1:0]  m_tag   [`HTU_SETS][`HTU_WAYS];
  logic                   m_valid [`HTU_SETS][`HTU_WAYS];
  line_state_t            m_st0   [`HTU_SETS][`HTU_WAYS];
  line_state_t            m_st1   [`HTU_SETS][`HTU_WAYS];
  logic [`HTU_WAY_W-1:0]  m_ptr   [`HTU_SETS];

  logic [`HTU_INDEX_W-1:0] idx;
  logic                    exp_hit;
  logic [`HTU_WAY_W-1:0]   exp_hit_way;
  logic [`HTU_WAY_W-1:0]   exp_way;
  line_state_t             exp_st0;
  line_state_t             exp_st1;
  line_state_t             half_st;
  line_state_t             new_st;
  logic                    exp_linefill;
  logic                    exp_evict;
  logic                    exp_allow;
  logic                    exp_isu_valid;
  logic                    exp_arvalid;
  logic                    exp_awvalid;
  logic [`HTU_ISSUE_W-1:0] exp_swo;
  logic [`HTU_ADDR_W-6:0]  exp_awaddr;

  assign idx = req_addr_i.f.index;

  always_comb begin
    logic vic_dirty;
    exp_hit     = 1'b0;
    exp_hit_way = '0;
    for (int w = 0; w < `HTU_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == req_addr_i.f.tag) begin
        exp_hit     = 1'b1;
        exp_hit_way = 3'(w);
      end
    end
    exp_way   = exp_hit ? exp_hit_way : m_ptr[idx];
    exp_st0   = exp_hit ? m_st0[idx][exp_hit_way] : EMPTY;
    exp_st1   = exp_hit ? m_st1[idx][exp_hit_way] : EMPTY;
    half_st   = req_addr_i.f.offset ? exp_st1 : exp_st0;
    vic_dirty = (m_st0[idx][m_ptr[idx]] == DIRTY) || (m_st1[idx][m_ptr[idx]] == DIRTY);
    exp_linefill  = !req_write_i && (!exp_hit || half_st == EMPTY);
    exp_evict     = !exp_hit && m_valid[idx][m_ptr[idx]] && vic_dirty;
    exp_isu_valid = req_valid_i && (!exp_linefill || biu_arready_i)
                    && (!exp_evict || biu_awready_i);
    exp_allow     = isu_allow_i && (!exp_linefill || biu_arready_i)
                    && (!exp_evict || biu_awready_i);
    exp_arvalid   = req_valid_i && exp_linefill && isu_allow_i;
    exp_awvalid   = req_valid_i && exp_evict && isu_allow_i;
    exp_swo       = {idx, exp_way, req_addr_i.f.offset};
    exp_awaddr    = {m_tag[idx][m_ptr[idx]], req_addr_i.f.bank, idx};
    if (req_write_i) begin
      new_st = DIRTY;
    end else if (half_st == EMPTY) begin
      new_st = CLEAN;
    end else begin
      new_st = half_st;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < `HTU_SETS; s++) begin
        m_ptr[s] <= '0;
        for (int w = 0; w < `HTU_WAYS; w++) begin
          m_valid[s][w] <= 1'b0;
          m_st0[s][w]   <= EMPTY;
          m_st1[s][w]   <= EMPTY;
        end
      end
    end else if (req_valid_i && exp_allow) begin
      if (!exp_hit) begin
        m_valid[idx][exp_way] <= 1'b1;
        m_tag[idx][exp_way]   <= req_addr_i.f.tag;
        m_st0[idx][exp_way]   <= EMPTY;
        m_st1[idx][exp_way]   <= EMPTY;
        m_ptr[idx]            <= m_ptr[idx] + 3'd1;
      end
      if (req_addr_i.f.offset) begin
        m_st1[idx][exp_way] <= new_st;
      end else begin
        m_st0[idx][exp_way] <= new_st;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h at %0t",
             test_name, what, exp_v, act_v, $time);
  endtask

  chk_allow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_allow_o == exp_allow)
    else report_mismatch("req_allow_o", 32'($sampled(exp_allow)), 32'($sampled(req_allow_o)));

  chk_isu_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isu_valid_o == exp_isu_valid)
    else report_mismatch("isu_valid_o", 32'($sampled(exp_isu_valid)),
                         32'($sampled(isu_valid_o)));

  chk_arvalid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_arvalid_o == exp_arvalid)
    else report_mismatch("biu_arvalid_o", 32'($sampled(exp_arvalid)),
                         32'($sampled(biu_arvalid_o)));

  chk_awvalid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_awvalid_o == exp_awvalid)
    else report_mismatch("biu_awvalid_o", 32'($sampled(exp_awvalid)),
                         32'($sampled(biu_awvalid_o)));

  chk_set_way : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> isu_set_way_offset_o == exp_swo)
    else report_mismatch("isu_set_way_offset_o", 32'($sampled(exp_swo)),
                         32'($sampled(isu_set_way_offset_o)));

  chk_linefill : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> isu_linefill_o == exp_linefill)
    else report_mismatch("isu_linefill_o", 32'($sampled(exp_linefill)),
                         32'($sampled(isu_linefill_o)));

  chk_evict : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> isu_evict_o == exp_evict)
    else report_mismatch("isu_evict_o", 32'($sampled(exp_evict)), 32'($sampled(isu_evict_o)));

  chk_states : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> {isu_state0_o, isu_state1_o} == {exp_st0, exp_st1})
    else report_mismatch("isu_state1_o/0", 32'({$sampled(exp_st1), $sampled(exp_st0)}),
                         32'({$sampled(isu_state1_o), $sampled(isu_state0_o)}));

  // write flag and channel id pass straight through
  chk_passthru : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> {isu_write_o, isu_ch_id_o} == {req_write_i, req_ch_id_i})
    else report_mismatch("isu_write_o/ch_id", 32'($sampled({req_write_i, req_ch_id_i})),
                         32'($sampled({isu_write_o, isu_ch_id_o})));

  chk_araddr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    biu_arvalid_o |-> biu_araddr_o == req_addr_i.l.line)
    else report_mismatch("biu_araddr_o", 32'($sampled(req_addr_i.l.line)),
                         32'($sampled(biu_araddr_o)));

  chk_awaddr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_awvalid |-> biu_awaddr_o == exp_awaddr)
    else report_mismatch("biu_awaddr_o", 32'($sampled(exp_awaddr)),
                         32'($sampled(biu_awaddr_o)));

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  function automatic logic [15:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic htu_addr_t make_addr(input logic [`HTU_TAG_W-1:0] tag,
                                          input logic [`HTU_BANK_W-1:0] bank,
                                          input logic [`HTU_INDEX_W-1:0] index,
                                          input logic offset);
    htu_addr_t a;
    a.f.tag    = tag;
    a.f.bank   = bank;
    a.f.index  = index;
    a.f.offset = offset;
    return a;
  endfunction

  // each ready low about one cycle in four
  task automatic drive_readies(input bit stall);
    logic [15:0] r;
    r = rand_next();
    isu_allow_i   = !stall || (r[15:14] != 2'b00);
    biu_arready_i = !stall || (r[13:12] != 2'b00);
    biu_awready_i = !stall || (r[11:10] != 2'b00);
  endtask

  // offered at a falling edge, held until allow is seen
  task automatic send_req(input logic write, input htu_addr_t addr, input bit stall);
    logic        accepted;
    logic [15:0] r;
    r           = rand_next();
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_ch_id_i = r[1:0];
    accepted    = 1'b0;
    while (!accepted) begin
      drive_readies(stall);
      #(CLK_PERIOD / 4);
      accepted = req_allow_o;
      @(negedge clk_i);
    end
    req_valid_i = 1'b0;
    n_trans++;
  endtask

  task automatic hold_req(input logic write, input htu_addr_t addr, input logic allow,
                          input logic ar, input logic aw, input int cycles);
    req_valid_i   = 1'b1;
    req_write_i   = write;
    req_addr_i    = addr;
    isu_allow_i   = allow;
    biu_arready_i = ar;
    biu_awready_i = aw;
    repeat (cycles) @(negedge clk_i);
  endtask

  initial begin
    logic [15:0] r;
    htu_addr_t   addr;
    errors        = 0;
    n_trans       = 0;
    lcg_state     = 32'd91615;
    test_name     = "reset";
    rst_n_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_write_i   = 1'b0;
    req_ch_id_i   = '0;
    req_addr_i    = '0;
    isu_allow_i   = 1'b1;
    biu_arready_i = 1'b1;
    biu_awready_i = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    test_name = "first_miss";
    send_req(1'b0, make_addr(22'h100, 2'd0, 3'd1, 1'b0), 1'b0);
    test_name = "same_half_hit";
    send_req(1'b0, make_addr(22'h100, 2'd0, 3'd1, 1'b0), 1'b0);
    test_name = "other_half_fill";
    send_req(1'b0, make_addr(22'h100, 2'd0, 3'd1, 1'b1), 1'b0);

    // way 0 of set 2 turns dirty, the eighth read miss wraps onto it
    test_name = "write_alloc";
    send_req(1'b1, make_addr(22'h200, 2'd1, 3'd2, 1'b1), 1'b0);
    test_name = "dirty_evict";
    for (int i = 1; i <= 8; i++) begin
      send_req(1'b0, make_addr(22'h200 + 22'(i), 2'd1, 3'd2, 1'b0), 1'b0);
    end

    test_name = "round_robin";
    for (int i = 0; i < 9; i++) begin
      send_req(1'b0, make_addr(22'h280 + 22'(i), 2'd2, 3'd3, 1'b0), 1'b0);
    end

    test_name = "backpressure";
    addr = make_addr(22'h300, 2'd3, 3'd5, 1'b0);
    hold_req(1'b0, addr, 1'b1, 1'b0, 1'b1, 3);
    hold_req(1'b0, addr, 1'b0, 1'b1, 1'b1, 2);
    send_req(1'b0, addr, 1'b0);
    hold_req(1'b0, addr, 1'b0, 1'b1, 1'b1, 2);
    send_req(1'b0, addr, 1'b0);

    // small tag pool, more tags than ways per set
    test_name = "random";
    for (int i = 0; i < N_RANDOM; i++) begin
      r    = rand_next();
      addr = make_addr(22'h3a0 + 22'(r % 16'd12), r[5:4], r[10:8], r[11]);
      send_req(r[12], addr, 1'b1);
      if (r[13]) begin
        drive_readies(1'b1);
        @(negedge clk_i);
      end
    end

    repeat (2) @(negedge clk_i);
    $display("transactions %0d, errors %0d", n_trans, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, transactions %0d, errors %0d",
             TIMEOUT_NS, n_trans, errors);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/htu_pkg.sv
source/htu_tag_array.sv
source/htu_victim_select.sv
source/htu_dispatch.sv
source/bank_htu_top.sv
sim/tb_bank_htu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the HTU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_bank_htu_top -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$OBJ/Vtb_bank_htu_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
